// File: design/isaPkg.sv
// Instruction set types, field positions and register-read rules shared by fetch RTL and testbench
package isaPkg;

   typedef logic [15:0] instrT;
   typedef logic [2:0]  regIdxT;

   // Major opcode in bits 15 to 11
   typedef enum logic [4:0] {
      opNop   = 5'b00000,
      opHalt  = 5'b00001,
      opJ     = 5'b00100,
      opJr    = 5'b00101,
      opAddi  = 5'b01000,
      opBeqz  = 5'b01100,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opRtype = 5'b11011
   } opcodeT;

   // Low bit of each instruction field
   localparam int opField = 11;
   localparam int rsField = 8;
   localparam int rtField = 5;

   localparam instrT nopInstr = '0;

   // Everything but NOP, HALT and J takes rs as a source
   function automatic logic readsRs(input opcodeT op);
      return !(op inside {opNop, opHalt, opJ});
   endfunction

   // Store data and the second ALU operand come from rt
   function automatic logic readsRt(input opcodeT op);
      return op inside {opRtype, opSt};
   endfunction

   function automatic logic isBranch(input opcodeT op);
      return op inside {opBeqz, opJ, opJr};
   endfunction

endpackage

// File: design/pipePkg.sv
// Pipeline status and fetch output types plus memory sizing, used across the fetch stage
package pipePkg;

   import isaPkg::*;

   typedef logic [15:0] addrT;

   // What one downstream stage currently holds
   typedef struct packed {
      logic   regWrt;
      regIdxT wrtReg;
      logic   branchInst;
   } stageStatT;

   // Everything fetch hands to decode
   typedef struct packed {
      instrT instruction;
      addrT  incPC;
      logic  instrValid;
      logic  branchInstF;
   } fetchOutT;

   localparam int memWords = 256;

   // Word index width, taken from pc bits above the byte offset
   localparam int memAddrBits = $clog2(memWords);

endpackage

// File: design/pcUnit.sv
// Program counter with +2 increment and branch redirect that the fetch stage top instantiates
`timescale 1ns/1ps

module pcUnit import pipePkg::*; (
   input  logic clk,
   input  logic rst,
   input  logic createDump,
   input  logic pcHold,
   input  logic branchTaken,
   input  addrT newPC,
   output addrT pc,
   output addrT incPC,
   output logic err
);

   logic incCarry;
   logic misaligned;
   addrT branchTarget;

   // Carry out of the add means pc wrapped past FFFE
   assign {incCarry, incPC} = {1'b0, pc} + 17'd2;

   assign misaligned = branchTaken & newPC[0];

   // Odd targets are forced onto a word boundary and flagged through err
   assign branchTarget = {newPC[15:1], 1'b0};

   assign err = incCarry | misaligned;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (createDump) begin
         // Halt wins over a pending redirect
         pc <= pc;
      end else if (branchTaken) begin
         pc <= branchTarget;
      end else if (!pcHold) begin
         pc <= incPC;
      end
   end

   // Instructions are halfword aligned so pc must stay even
   pcAligned: assert property (@(posedge clk) disable iff (rst) !pc[0])
      else $error("pc became odd: %h", pc);

endmodule

// File: design/instrMem.sv
// Word-addressed instruction store that fetch reads at pc and the loader fills through a write port
`timescale 1ns/1ps

module instrMem import isaPkg::*, pipePkg::*; (
   input  logic  clk,
   input  addrT  pc,
   input  logic  progWrEn,
   input  addrT  progAddr,
   input  instrT progData,
   output instrT rawInstr
);

   instrT mem [memWords];

   logic [memAddrBits-1:0] rdIdx;
   logic [memAddrBits-1:0] wrIdx;

   // Bit 0 of a byte address is the offset within the word
   assign rdIdx = pc[memAddrBits:1];
   assign wrIdx = progAddr[memAddrBits:1];

   assign rawInstr = mem[rdIdx];

   // Program load is visible to the read port the following cycle
   always_ff @(posedge clk) begin
      if (progWrEn) begin
         mem[wrIdx] <= progData;
      end
   end

   // Loader must write whole instruction words
   loadAligned: assert property (@(posedge clk) progWrEn |-> !progAddr[0])
      else $error("odd program load address %h", progAddr);

endmodule

// File: design/hazardDetect.sv
// Combinational RAW and branch-in-flight check that the fetch stage top uses to stall and bubble
`timescale 1ns/1ps

module hazardDetect import isaPkg::*, pipePkg::*; (
   input  instrT     rawInstr,
   input  stageStatT statD,
   input  stageStatT statX,
   input  stageStatT statM,
   input  stageStatT statW,
   output instrT     instruction,
   output logic      instrValid,
   output logic      branchInstF,
   output logic      pcHold
);

   opcodeT op;
   regIdxT rs;
   regIdxT rt;
   logic   rdRs;
   logic   rdRt;
   logic   rsHit;
   logic   rtHit;
   logic   dataHaz;
   logic   branchHaz;

   // True when this stage will write register r
   function automatic logic writes(input stageStatT s, input regIdxT r);
      return s.regWrt && (s.wrtReg == r);
   endfunction

   // Writeback counts as a writer since there is no bypass
   function automatic logic anyWriter(
      input stageStatT d,
      input stageStatT x,
      input stageStatT m,
      input stageStatT w,
      input regIdxT    r
   );
      return writes(d, r) | writes(x, r) | writes(m, r) | writes(w, r);
   endfunction

   // Field decode
   assign op = opcodeT'(rawInstr[opField +: $bits(opcodeT)]);
   assign rs = rawInstr[rsField +: $bits(regIdxT)];
   assign rt = rawInstr[rtField +: $bits(regIdxT)];

   assign rdRs = readsRs(op);
   assign rdRt = readsRt(op);

   assign rsHit = rdRs & anyWriter(statD, statX, statM, statW, rs);
   assign rtHit = rdRt & anyWriter(statD, statX, statM, statW, rt);

   assign dataHaz = rsHit | rtHit;

   // Redirect not resolved until writeback, so nothing is fetched meanwhile
   assign branchHaz = statD.branchInst | statX.branchInst | statM.branchInst;

   assign pcHold = dataHaz | branchHaz;

   // Bubble while stalled
   assign instruction = pcHold ? nopInstr : rawInstr;
   assign instrValid  = ~pcHold;
   assign branchInstF = ~pcHold & isBranch(op);

endmodule

// File: design/fetchStage.sv
// Fetch stage top, joining pc, instruction memory and hazard check into the decode-facing struct
`timescale 1ns/1ps

module fetchStage import isaPkg::*, pipePkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      createDump,
   input  addrT      newPC,
   input  stageStatT statD,
   input  stageStatT statX,
   input  stageStatT statM,
   input  stageStatT statW,
   input  logic      progWrEn,
   input  addrT      progAddr,
   input  instrT     progData,
   output fetchOutT  fetchOut,
   output logic      err
);

   addrT  pc;
   addrT  incPC;
   instrT rawInstr;
   instrT instruction;
   logic  instrValid;
   logic  branchInstF;
   logic  pcHold;

   pcUnit pcUnit_i (
      .clk         (clk),
      .rst         (rst),
      .createDump  (createDump),
      .pcHold      (pcHold),
      .branchTaken (statW.branchInst),
      .newPC       (newPC),
      .pc          (pc),
      .incPC       (incPC),
      .err         (err)
   );

   instrMem instrMem_i (
      .clk      (clk),
      .pc       (pc),
      .progWrEn (progWrEn),
      .progAddr (progAddr),
      .progData (progData),
      .rawInstr (rawInstr)
   );

   hazardDetect hazardDetect_i (
      .rawInstr    (rawInstr),
      .statD       (statD),
      .statX       (statX),
      .statM       (statM),
      .statW       (statW),
      .instruction (instruction),
      .instrValid  (instrValid),
      .branchInstF (branchInstF),
      .pcHold      (pcHold)
   );

   assign fetchOut = '{
      instruction: instruction,
      incPC:       incPC,
      instrValid:  instrValid,
      branchInstF: branchInstF
   };

endmodule

// File: testbench/fetchChecker.sv
// Output checker for the fetch stage, samples late in each cycle and counts mismatches
`timescale 1ns/1ps

module fetchChecker import pipePkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  logic     checkEn,
   input  fetchOutT fetchOut,
   input  logic     err,
   input  fetchOutT expOut,
   input  logic     expErr,
   output int       errCount,
   output int       checkCount,
   output logic     resetTimedOut
);

   localparam int resetWaitLimit = 20;

   task automatic compareField(input string name, input logic [15:0] expVal,
                               input logic [15:0] actVal);
      if (actVal !== expVal) begin
         errCount++;
         $display("** Error %s: expected %h, actual %h at %0t", name, expVal, actVal, $time);
      end
   endtask

   initial begin
      int waitCycles;
      errCount = 0;
      checkCount = 0;
      resetTimedOut = 1'b0;
      waitCycles = 0;
      // Mid-cycle look at rst until it drops
      do begin
         @(negedge clk);
         waitCycles++;
      end while (rst && waitCycles < resetWaitLimit);
      if (rst) begin
         resetTimedOut = 1'b1;
         $display("Reset was still asserted after %0d cycles, nothing was checked", waitCycles);
      end else begin
         forever begin
            // 2 ns before the rising edge, inputs settled since 1 ns after the last one
            #3;
            if (checkEn) begin
               checkCount++;
               compareField("fetchOut.instruction", expOut.instruction, fetchOut.instruction);
               compareField("fetchOut.incPC", expOut.incPC, fetchOut.incPC);
               compareField("fetchOut.instrValid", 16'(expOut.instrValid),
                            16'(fetchOut.instrValid));
               compareField("fetchOut.branchInstF", 16'(expOut.branchInstF),
                            16'(fetchOut.branchInstF));
               compareField("err", 16'(expErr), 16'(err));
            end
            @(negedge clk);
         end
      end
   end

endmodule

// File: testbench/fetchTb.sv
// Fetch stage testbench top, loads the program during reset and replays the per-cycle vectors
`timescale 1ns/1ps

module fetchTb import isaPkg::*, pipePkg::*; ();

   localparam int    resetCycles = 5;
   localparam int    maxCycles   = 200;
   localparam int    maxTokens   = 1000;
   localparam string vecFile     = "testbench/fetchVectors.txt";

   // One C record of the vectors file
   typedef struct packed {
      logic       dump;
      addrT       newPC;
      logic [7:0] codeD;
      logic [7:0] codeX;
      logic [7:0] codeM;
      logic [7:0] codeW;
      fetchOutT   expOut;
      logic       expErr;
   } cycleVecT;

   logic      clk;
   logic      rst;
   logic      createDump;
   addrT      newPC;
   stageStatT statD;
   stageStatT statX;
   stageStatT statM;
   stageStatT statW;
   logic      progWrEn;
   addrT      progAddr;
   instrT     progData;
   fetchOutT  fetchOut;
   logic      err;
   logic      checkEn;
   fetchOutT  expOut;
   logic      expErr;
   int        errCount;
   int        checkCount;
   logic      resetTimedOut;
   int        otherFails;

   addrT     loadAddrQ[$];
   instrT    loadDataQ[$];
   cycleVecT cycleQ[$];

   fetchStage fetchStage_i (.*);

   fetchChecker outChecker (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Code ff is an idle stage whose wrtReg is filler
   function automatic stageStatT toStatus(input logic [7:0] code);
      stageStatT s;
      if (code == 8'hff) begin
         s.regWrt = 1'b0;
         s.wrtReg = regIdxT'($urandom % 8);
         s.branchInst = 1'b0;
      end else begin
         s = stageStatT'(code[4:0]);
      end
      return s;
   endfunction

   task automatic readVectors();
      int               fd;
      int               n;
      int               tokens;
      logic [7:0]       tag;
      logic [8*160-1:0] rest;
      addrT             a;
      instrT            d;
      cycleVecT         v;
      logic             dumpV, eValid, eBr, eErr;
      logic [7:0]       cD, cX, cM, cW;
      addrT             pcV, eInc;
      instrT            eInstr;
      fd = $fopen(vecFile, "r");
      if (fd == 0) begin
         $display("Could not open the vectors file %s", vecFile);
         otherFails++;
         return;
      end
      tokens = 0;
      while (!$feof(fd) && tokens < maxTokens) begin
         n = $fscanf(fd, "%s", tag);
         if (n != 1) break;
         tokens++;
         case (tag)
            "#": n = $fgets(rest, fd);
            "P": begin
               n = $fscanf(fd, "%h %h", a, d);
               loadAddrQ.push_back(a);
               loadDataQ.push_back(d);
            end
            "C": begin
               n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", dumpV, pcV, cD, cX, cM, cW,
                           eInstr, eInc, eValid, eBr, eErr);
               v = '{dumpV, pcV, cD, cX, cM, cW, '{eInstr, eInc, eValid, eBr}, eErr};
               cycleQ.push_back(v);
            end
            default: begin
               $display("Unknown record type in the vectors file");
               otherFails++;
               n = $fgets(rest, fd);
            end
         endcase
      end
      $fclose(fd);
   endtask

   task automatic loadProgram();
      for (int i = 0; i < resetCycles; i++) begin
         progWrEn = (i < loadAddrQ.size());
         if (progWrEn) begin
            progAddr = loadAddrQ[i];
            progData = loadDataQ[i];
         end
         @(posedge clk);
         #1;
      end
      progWrEn = 1'b0;
      rst = 1'b0;
      if (loadAddrQ.size() > resetCycles) begin
         $display("The program has more words than there are reset cycles to load them");
         otherFails++;
      end
   endtask

   task automatic runCycles();
      cycleVecT v;
      for (int cyc = 0; cyc < cycleQ.size(); cyc++) begin
         if (cyc >= maxCycles) begin
            $display("Gave up after %0d cycles with vectors still left", cyc);
            otherFails++;
            break;
         end
         v = cycleQ[cyc];
         createDump = v.dump;
         newPC = v.newPC;
         statD = toStatus(v.codeD);
         statX = toStatus(v.codeX);
         statM = toStatus(v.codeM);
         statW = toStatus(v.codeW);
         expOut = v.expOut;
         expErr = v.expErr;
         checkEn = 1'b1;
         @(posedge clk);
         #1;
      end
      checkEn = 1'b0;
   endtask

   initial begin
      void'($urandom(71));
      rst = 1'b1;
      createDump = 1'b0;
      newPC = '0;
      statD = '0;
      statX = '0;
      statM = '0;
      statW = '0;
      progWrEn = 1'b0;
      progAddr = '0;
      progData = '0;
      checkEn = 1'b0;
      expOut = '0;
      expErr = 1'b0;
      otherFails = 0;
      readVectors();
      loadProgram();
      runCycles();
      $display("Summary: %0d value errors, %0d other failures, %0d of %0d cycles checked",
               errCount, otherFails + int'(resetTimedOut), checkCount, cycleQ.size());
      if (errCount == 0 && otherFails == 0 && !resetTimedOut && cycleQ.size() > 0 &&
          checkCount == cycleQ.size()) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: testbench/fetchVectors.txt
# P byteAddr word | C dump newPC statD statX statM statW expInstr expIncPC expValid expBrF expErr
# stat is {regWrt,wrtReg,branchInst} in hex, ff is an idle stage with a random wrtReg
P 0000 4102
P 0002 da60
P 0004 6104
P 0006 2a00
P fffe 2010
C 0 0000 ff ff ff ff 4102 0002 1 0 0
C 0 0000 ff 16 ff ff 0000 0004 0 0 0
C 0 0000 ff ff ff 14 0000 0004 0 0 0
C 0 0000 1a ff 1e ff da60 0004 1 0 0
C 0 0000 12 ff ff ff 0000 0006 0 0 0
C 0 0000 ff ff ff ff 6104 0006 1 1 0
C 0 0000 01 ff ff ff 0000 0008 0 0 0
C 0 0000 ff 01 ff ff 0000 0008 0 0 0
C 0 0000 ff ff 01 ff 0000 0008 0 0 0
C 0 0002 ff ff ff 01 2a00 0008 1 1 0
C 0 0000 ff ff ff ff da60 0004 1 0 0
C 1 0000 ff ff ff ff 6104 0006 1 1 0
C 1 0000 ff ff ff 01 6104 0006 1 1 0
C 0 0003 ff ff ff 01 6104 0006 1 1 1
C 0 fffe ff ff ff 01 da60 0004 1 0 0
C 0 0000 ff ff ff ff 2010 0000 1 1 1
C 0 0000 ff ff ff 12 0000 0002 0 0 0
C 0 0000 ff ff ff ff 4102 0002 1 0 0

// File: filelist.f
design/isaPkg.sv
design/pipePkg.sv
design/pcUnit.sv
design/instrMem.sv
design/hazardDetect.sv
design/fetchStage.sv
testbench/fetchChecker.sv
testbench/fetchTb.sv

// File: run.sh
#!/bin/sh
# Builds the fetch stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module fetchTb -o fetchSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

simOut=$(./obj_dir/fetchSim)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if printf '%s\n' "$simOut" | grep -qxF '** PASS **'; then
   exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
